/* files.f */
lsu_pkg.sv
lsu_store_align.sv
lsu_axi_master.sv
lsu_load_extend.sv
lsu_sram.sv
lsu_top.sv
tb_lsu.sv

/* lsu_axi_master.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_axi_master (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      stg_valid,
    output logic                     stg_ready,
    input  wire lsu_pkg::mem_op_t    stg_op,
    input  wire lsu_pkg::addr_t      stg_addr,
    input  wire lsu_pkg::data_t      stg_wdata,
    input  wire lsu_pkg::strb_t      stg_strb,
    output logic                     ld_valid,
    input  wire                      ld_ready,
    output lsu_pkg::mem_op_t         ld_op,
    output logic [1:0]               ld_offset,
    output lsu_pkg::data_t           ld_rdata,
    output lsu_pkg::addr_t           araddr,
    output logic                     arvalid,
    input  wire                      arready,
    input  wire                      rvalid,
    input  wire lsu_pkg::data_t      rdata,
    output logic                     rready,
    output lsu_pkg::addr_t           awaddr,
    output logic                     awvalid,
    input  wire                      awready,
    output lsu_pkg::data_t           wdata,
    output logic                     wvalid,
    input  wire                      wready,
    output lsu_pkg::strb_t           wstrb,
    input  wire                      bvalid,
    output logic                     bready
);
    import lsu_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        READ_ADDR,
        READ_DATA,
        WRITE_ADDR,
        WRITE_RESP,
        DONE
    } state_t;

    state_t     state;
    mem_op_t    op_q;
    logic [1:0] offset_q;
    addr_t      addr_q;     // word aligned
    data_t      wdata_q;
    strb_t      strb_q;
    data_t      rdata_q;
    logic       aw_pend;    // aw not yet taken
    logic       w_pend;     // w not yet taken
    logic       aw_left;
    logic       w_left;

    assign stg_ready = (state == IDLE);
    assign arvalid   = (state == READ_ADDR);
    assign rready    = (state == READ_DATA);
    assign awvalid   = aw_pend;
    assign wvalid    = w_pend;
    assign bready    = (state == WRITE_RESP);
    assign ld_valid  = (state == DONE);

    assign araddr    = addr_q;
    assign awaddr    = addr_q;
    assign wdata     = wdata_q;
    assign wstrb     = strb_q;
    assign ld_op     = op_q;
    assign ld_offset = offset_q;
    assign ld_rdata  = rdata_q;

    // still owed after this cycle
    assign aw_left = aw_pend && !awready;
    assign w_left  = w_pend && !wready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (stg_valid) begin
                        if (is_store(stg_op)) begin
                            state   <= WRITE_ADDR;
                            aw_pend <= 1'b1; // aw and w go out together
                            w_pend  <= 1'b1;
                        end else begin
                            state <= READ_ADDR;
                        end
                    end
                end
                READ_ADDR: begin
                    if (arready) begin
                        state <= READ_DATA;
                    end
                end
                READ_DATA: begin
                    if (rvalid) begin
                        state <= DONE;
                    end
                end
                WRITE_ADDR: begin
                    aw_pend <= aw_left;
                    w_pend  <= w_left;
                    if (!aw_left && !w_left) begin
                        state <= WRITE_RESP;
                    end
                end
                WRITE_RESP: begin
                    if (bvalid) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    if (ld_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (stg_valid && stg_ready) begin
            op_q     <= stg_op;
            offset_q <= stg_addr[1:0];
            addr_q   <= {stg_addr[31:2], 2'b00};
            wdata_q  <= stg_wdata;
            strb_q   <= stg_strb;
        end
        if (rvalid && rready) begin
            rdata_q <= rdata;
        end else if (bvalid && bready) begin
            rdata_q <= '0; // stores complete with zero
        end
    end

    a_one_channel: assert property (@(posedge clk) disable iff (rst)
        !(arvalid && awvalid));
    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid);
    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid);
    a_w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid);
    a_ld_hold: assert property (@(posedge clk) disable iff (rst)
        ld_valid && !ld_ready |=> ld_valid && $stable(ld_rdata));

endmodule

`default_nettype wire

/* lsu_load_extend.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_load_extend (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      ld_valid,
    output logic                     ld_ready,
    input  wire lsu_pkg::mem_op_t    ld_op,
    input  wire [1:0]                ld_offset,
    input  wire lsu_pkg::data_t      ld_rdata,
    output logic                     resp_valid,
    input  wire                      resp_ready,
    output lsu_pkg::data_t           resp_rdata
);
    import lsu_pkg::*;

    data_t shifted;   // addressed byte moved to lane 0
    data_t result;

    assign shifted  = ld_rdata >> {ld_offset, 3'b000};
    assign ld_ready = ~resp_valid | resp_ready;

    always_comb begin
        case (ld_op)
            LB:      result = {{24{shifted[7]}}, shifted[7:0]};
            LBU:     result = {24'h0, shifted[7:0]};
            LH:      result = {{16{shifted[15]}}, shifted[15:0]};
            LHU:     result = {16'h0, shifted[15:0]};
            LW:      result = shifted;
            default: result = '0; // store completion
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else if (ld_valid && ld_ready) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ld_valid && ld_ready) begin
            resp_rdata <= result;
        end
    end

    // a stalled completion must not change under the core
    a_resp_hold: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata));

endmodule

`default_nettype wire

/* lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // widths with a meaning of their own
    typedef logic [31:0] addr_t;   // byte address
    typedef logic [31:0] data_t;   // one data word
    typedef logic [3:0]  strb_t;   // byte lanes of a word

    // load codes follow the core's decoder, stores fill the rest
    typedef enum logic [2:0] {
        SW  = 3'b000,
        LB  = 3'b001,
        LBU = 3'b010,
        LH  = 3'b011,
        LHU = 3'b100,
        LW  = 3'b101,
        SB  = 3'b110,
        SH  = 3'b111
    } mem_op_t;

    // default memory shape
    parameter int SRAM_WORDS   = 256;
    parameter int SRAM_LATENCY = 2;   // wait cycles before arready/awready

    function automatic logic is_store(mem_op_t op);
        logic res;
        case (op)
            SB, SH, SW: res = 1'b1;
            default:    res = 1'b0;
        endcase
        return res;
    endfunction

endpackage

`default_nettype wire

/* lsu_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_sram #(
    parameter int WORDS   = lsu_pkg::SRAM_WORDS,
    parameter int LATENCY = lsu_pkg::SRAM_LATENCY
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire lsu_pkg::addr_t      araddr,
    input  wire                      arvalid,
    output logic                     arready,
    output logic                     rvalid,
    output lsu_pkg::data_t           rdata,
    input  wire                      rready,
    input  wire lsu_pkg::addr_t      awaddr,
    input  wire                      awvalid,
    output logic                     awready,
    input  wire lsu_pkg::data_t      wdata,
    input  wire                      wvalid,
    output logic                     wready,
    input  wire lsu_pkg::strb_t      wstrb,
    output logic                     bvalid,
    input  wire                      bready
);
    import lsu_pkg::*;

    localparam int AW = $clog2(WORDS);
    localparam int CW = $clog2(LATENCY + 2);   // counts 0..LATENCY
    localparam logic [CW-1:0] LAT_CNT = CW'(LATENCY);

    typedef enum logic [1:0] {
        IDLE,
        READ_RESP,
        WRITE_RESP
    } state_t;

    state_t          state;
    logic [CW-1:0]   wait_cnt;   // cycles the pending valid has waited
    logic            rd_req;
    logic            wr_req;
    logic            wait_done;
    logic [AW-1:0]   rd_idx;
    logic [AW-1:0]   wr_idx;
    data_t           mem [WORDS];

    assign rd_idx = araddr[AW+1:2];
    assign wr_idx = awaddr[AW+1:2];

    // reads win if both show up, one transaction at a time
    assign rd_req    = (state == IDLE) && arvalid;
    assign wr_req    = (state == IDLE) && awvalid && wvalid && !arvalid;
    assign wait_done = (wait_cnt == LAT_CNT);

    assign arready = rd_req && wait_done;
    assign awready = wr_req && wait_done;
    assign wready  = wr_req && wait_done;  // aw and w taken together
    assign rvalid  = (state == READ_RESP);
    assign bvalid  = (state == WRITE_RESP);

    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt <= '0;
        end else if (arready || awready) begin
            wait_cnt <= '0;
        end else if (rd_req || wr_req) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (arready) begin
                        state <= READ_RESP;
                    end else if (awready) begin
                        state <= WRITE_RESP;
                    end
                end
                READ_RESP: begin
                    if (rready) begin
                        state <= IDLE;
                    end
                end
                WRITE_RESP: begin
                    if (bready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (awready) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    mem[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arready) begin
            rdata <= mem[rd_idx]; // shows up with rvalid next cycle
        end
    end

endmodule

`default_nettype wire

/* lsu_store_align.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_store_align (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      req_valid,
    output logic                     req_ready,
    input  wire lsu_pkg::mem_op_t    req_op,
    input  wire lsu_pkg::addr_t      req_addr,
    input  wire lsu_pkg::data_t      req_wdata,
    output logic                     stg_valid,
    input  wire                      stg_ready,
    output lsu_pkg::mem_op_t         stg_op,
    output lsu_pkg::addr_t           stg_addr,
    output lsu_pkg::data_t           stg_wdata,
    output lsu_pkg::strb_t           stg_strb
);
    import lsu_pkg::*;

    logic       full;
    logic [1:0] offset;
    strb_t      base_strb;   // strobe before the lane shift

    assign offset    = req_addr[1:0];
    assign stg_valid = full;
    assign req_ready = ~full | stg_ready; // free, or emptying this cycle

    always_comb begin
        case (req_op)
            SB:      base_strb = 4'b0001;
            SH:      base_strb = 4'b0011;
            SW:      base_strb = 4'b1111;
            default: base_strb = 4'b0000; // loads
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (req_valid && req_ready) begin
            full <= 1'b1;
        end else if (stg_ready) begin
            full <= 1'b0;
        end
    end

    // lanes shifted past byte 3 fall off the top
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            stg_op    <= req_op;
            stg_addr  <= req_addr;
            stg_wdata <= req_wdata << {offset, 3'b000};
            stg_strb  <= base_strb << offset;
        end
    end

    // an offered request waits for the bus stage
    a_stg_hold: assert property (@(posedge clk) disable iff (rst)
        stg_valid && !stg_ready |=> stg_valid);

endmodule

`default_nettype wire

/* lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
    parameter int SRAM_WORDS   = lsu_pkg::SRAM_WORDS,
    parameter int SRAM_LATENCY = lsu_pkg::SRAM_LATENCY
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      req_valid,
    output logic                     req_ready,
    input  wire lsu_pkg::mem_op_t    req_op,
    input  wire lsu_pkg::addr_t      req_addr,
    input  wire lsu_pkg::data_t      req_wdata,
    output logic                     resp_valid,
    input  wire                      resp_ready,
    output lsu_pkg::data_t           resp_rdata
);
    import lsu_pkg::*;

    // align -> bus stage
    logic    stg_valid;
    logic    stg_ready;
    mem_op_t stg_op;
    addr_t   stg_addr;
    data_t   stg_wdata;
    strb_t   stg_strb;

    // bus -> load format stage
    logic       ld_valid;
    logic       ld_ready;
    mem_op_t    ld_op;
    logic [1:0] ld_offset;
    data_t      ld_rdata;

    // AXI-lite to the SRAM
    addr_t araddr;
    logic  arvalid;
    logic  arready;
    logic  rvalid;
    data_t rdata;
    logic  rready;
    addr_t awaddr;
    logic  awvalid;
    logic  awready;
    data_t wdata;
    logic  wvalid;
    logic  wready;
    strb_t wstrb;
    logic  bvalid;
    logic  bready;

    lsu_store_align u_align (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_ready(req_ready),
        .req_op(req_op), .req_addr(req_addr), .req_wdata(req_wdata),
        .stg_valid(stg_valid), .stg_ready(stg_ready),
        .stg_op(stg_op), .stg_addr(stg_addr),
        .stg_wdata(stg_wdata), .stg_strb(stg_strb)
    );

    lsu_axi_master u_master (
        .clk(clk), .rst(rst),
        .stg_valid(stg_valid), .stg_ready(stg_ready),
        .stg_op(stg_op), .stg_addr(stg_addr),
        .stg_wdata(stg_wdata), .stg_strb(stg_strb),
        .ld_valid(ld_valid), .ld_ready(ld_ready),
        .ld_op(ld_op), .ld_offset(ld_offset), .ld_rdata(ld_rdata),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rvalid(rvalid), .rdata(rdata), .rready(rready),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready), .wstrb(wstrb),
        .bvalid(bvalid), .bready(bready)
    );

    lsu_load_extend u_extend (
        .clk(clk), .rst(rst),
        .ld_valid(ld_valid), .ld_ready(ld_ready),
        .ld_op(ld_op), .ld_offset(ld_offset), .ld_rdata(ld_rdata),
        .resp_valid(resp_valid), .resp_ready(resp_ready),
        .resp_rdata(resp_rdata)
    );

    lsu_sram #(
        .WORDS(SRAM_WORDS),
        .LATENCY(SRAM_LATENCY)
    ) u_sram (
        .clk(clk), .rst(rst),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rvalid(rvalid), .rdata(rdata), .rready(rready),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready), .wstrb(wstrb),
        .bvalid(bvalid), .bready(bready)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, scan the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_lsu -f files.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_lsu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    exit 1
fi
exit 0

/* tb_lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;
    import lsu_pkg::*;

    localparam int WORDS        = lsu_pkg::SRAM_WORDS;
    localparam int LATENCY      = lsu_pkg::SRAM_LATENCY;
    localparam int WBITS        = $clog2(WORDS);
    localparam int NUM_REQ      = 200;
    localparam int CYCLE_LIMIT  = NUM_REQ * (LATENCY + 8) * 2;
    localparam int N_RANDOM     = 140;
    localparam int HOLD         = 20;   // stalled cycles watched on req_ready
    localparam int STALL_NONE   = 0;
    localparam int STALL_RANDOM = 1;
    localparam int STALL_HOLD   = 2;
    localparam int T_STORE_LOAD = 0;
    localparam int T_STROBE     = 1;
    localparam int T_MISALIGNED = 2;
    localparam int T_RANDOM     = 3;
    localparam int T_BACKPRESS  = 4;
    localparam mem_op_t LOAD_OPS [5] = '{LW, LH, LHU, LB, LBU};

    logic    clk;
    logic    rst;
    logic    req_valid;
    logic    req_ready;
    mem_op_t req_op;
    addr_t   req_addr;
    data_t   req_wdata;
    logic    resp_valid;
    logic    resp_ready;
    data_t   resp_rdata;

    logic [31:0] lfsr;
    logic [7:0]  model [0:WORDS*4-1];     // byte image of the SRAM
    data_t       exp_mem [0:NUM_REQ-1];   // expected completions in request order
    int          tag_mem [0:NUM_REQ-1];
    logic        stall_pat [0:CYCLE_LIMIT-1];
    int          stall_mode;
    int          n_issued;
    int          n_done;
    int          cycles;
    int          err_proc;
    int          err_value;
    int          err_stable;
    int          err_extra;

    lsu_top #(
        .SRAM_WORDS(WORDS),
        .SRAM_LATENCY(LATENCY)
    ) dut (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_ready(req_ready),
        .req_op(req_op), .req_addr(req_addr), .req_wdata(req_wdata),
        .resp_valid(resp_valid), .resp_ready(resp_ready), .resp_rdata(resp_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one step per bit, newest bit at the bottom
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic string test_name(input int tag);
        case (tag)
            T_STORE_LOAD: return "store_load";
            T_STROBE:     return "byte_strobe";
            T_MISALIGNED: return "misaligned";
            T_RANDOM:     return "random_stall";
            T_BACKPRESS:  return "backpressure";
            default:      return "unknown";
        endcase
    endfunction

    // bytes from the offset upwards, zeros past the top of the word
    function automatic data_t load_expect(input mem_op_t op, input int word, input int off);
        logic [7:0] b [4];
        data_t      res;
        for (int k = 0; k < 4; k++) begin
            b[k] = (off + k < 4) ? model[word*4 + off + k] : 8'h00;
        end
        case (op)
            LB:      res = {{24{b[0][7]}}, b[0]};
            LBU:     res = {24'h0, b[0]};
            LH:      res = {{16{b[1][7]}}, b[1], b[0]};
            LHU:     res = {16'h0, b[1], b[0]};
            LW:      res = {b[3], b[2], b[1], b[0]};
            default: res = '0;
        endcase
        return res;
    endfunction

    task automatic apply_store(input mem_op_t op, input int word, input int off, input data_t data);
        int size;
        size = (op == SB) ? 1 : ((op == SH) ? 2 : 4);
        for (int k = 0; k < size; k++) begin
            if (off + k < 4) begin
                model[word*4 + off + k] = data[8*k +: 8];
            end
        end
    endtask

    task automatic present(input mem_op_t op, input int word, input int off, input data_t data);
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr_t'(word * 4 + off);
        req_wdata = data;
    endtask

    // transfer happens on the edge after the negedge that sees req_ready
    task automatic await_accept(input int tag);
        int word;
        int off;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        word = int'(req_addr[31:2]);
        off  = int'(req_addr[1:0]);
        if (req_op == SB || req_op == SH || req_op == SW) begin
            apply_store(req_op, word, off, req_wdata);
            exp_mem[n_issued] = '0;
        end else begin
            exp_mem[n_issued] = load_expect(req_op, word, off);
        end
        tag_mem[n_issued] = tag;
        n_issued++;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic send(input mem_op_t op, input int word, input int off, input data_t data,
                        input int tag);
        present(op, word, off, data);
        await_accept(tag);
    endtask

    task automatic drain();
        @(negedge clk);
        while (n_done != n_issued) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    // resp_ready pattern chosen at negedge, driven after the next rising edge
    initial begin
        int   k;
        logic pick;
        k = 0;
        pick = 1'b1;
        resp_ready = 1'b1;
        forever begin
            @(negedge clk);
            if (stall_mode == STALL_RANDOM) begin
                pick = stall_pat[k % CYCLE_LIMIT];
            end else begin
                pick = (stall_mode == STALL_NONE);
            end
            k++;
            @(posedge clk);
            #1;
            resp_ready = pick;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            n_done <= 0;
        end else if (resp_valid && resp_ready) begin
            n_done <= n_done + 1;
        end
    end

    a_resp_value: assert property (@(posedge clk) disable iff (rst)
        resp_valid && resp_ready |-> resp_rdata == exp_mem[n_done])
        else begin
            err_value++;
            $display("Fail %s: expected %h, actual %h", test_name(tag_mem[$sampled(n_done)]),
                     exp_mem[$sampled(n_done)], $sampled(resp_rdata));
        end

    a_resp_stable: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata))
        else begin
            err_stable++;
            $display("completion changed or vanished while resp_ready was low");
        end

    a_no_extra: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> n_done < n_issued)
        else begin
            err_extra++;
            $display("completion offered with no request outstanding");
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, %0d of %0d requests completed",
                     cycles, n_done, n_issued);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] bits;
        int          word;
        int          low_cnt;
        mem_op_t     op;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_op     = LW;
        req_addr   = '0;
        req_wdata  = '0;
        stall_mode = STALL_NONE;
        n_issued   = 0;
        lfsr       = 32'h4ae0_c59c;
        for (int i = 0; i < WORDS*4; i++) begin
            model[i] = 8'h00;   // SRAM clears on reset
        end
        for (int i = 0; i < CYCLE_LIMIT; i++) begin
            bits = take_bits(1);
            stall_pat[i] = bits[0];
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        @(negedge clk);
        assert (!resp_valid) else begin
            err_proc++;
            $display("Fail reset: expected resp_valid 0, actual %b", resp_valid);
        end
        assert (req_ready) else begin
            err_proc++;
            $display("Fail reset: expected req_ready 1, actual %b", req_ready);
        end
        @(posedge clk);
        #1;

        // every load flavour at every offset after a full word store
        for (int off = 0; off < 4; off++) begin
            bits = take_bits(WBITS);
            word = int'(bits);
            send(SW, word, 0, take_bits(32), T_STORE_LOAD);
            for (int k = 0; k < 5; k++) begin
                send(LOAD_OPS[k], word, off, 32'h0, T_STORE_LOAD);
            end
        end

        for (int off = 0; off < 4; off++) begin
            bits = take_bits(WBITS);
            word = int'(bits);
            send(SW, word, 0, take_bits(32), T_STROBE);
            send(SB, word, off, take_bits(32), T_STROBE);
            send(LW, word, 0, 32'h0, T_STROBE);
            send(SH, word, off, take_bits(32), T_STROBE);   // upper byte drops at offset 3
            send(LW, word, 0, 32'h0, T_STROBE);
        end

        bits = take_bits(WBITS);
        word = int'(bits);
        send(SW, word, 0, take_bits(32) | 32'h8080_8080, T_MISALIGNED);
        send(LH, word, 1, 32'h0, T_MISALIGNED);
        send(LH, word, 3, 32'h0, T_MISALIGNED);
        for (int off = 1; off < 4; off++) begin
            send(LW, word, off, 32'h0, T_MISALIGNED);
        end

        stall_mode = STALL_RANDOM;
        for (int i = 0; i < N_RANDOM; i++) begin
            bits = take_bits(3);
            op = mem_op_t'(bits[2:0]);
            bits = take_bits(4);   // small window so loads see earlier stores
            word = int'(bits);
            bits = take_bits(2);
            send(op, word, int'(bits), take_bits(32), T_RANDOM);
        end
        stall_mode = STALL_NONE;
        drain();

        // three requests fill the pipe, the fourth must wait
        stall_mode = STALL_HOLD;
        repeat (2) @(posedge clk);
        #1;
        for (int i = 0; i < 3; i++) begin
            send(LW, i, 0, 32'h0, T_BACKPRESS);
        end
        present(SW, 3, 0, take_bits(32));
        low_cnt = 0;
        repeat (HOLD) begin
            @(negedge clk);
            if (!req_ready) begin
                low_cnt++;
            end
        end
        assert (low_cnt == HOLD) else begin
            err_proc++;
            $display("Fail backpressure: expected %0d cycles of req_ready low, actual %0d",
                     HOLD, low_cnt);
        end
        @(posedge clk);
        #1;
        stall_mode = STALL_NONE;
        await_accept(T_BACKPRESS);
        drain();

        repeat (10) @(posedge clk);
        @(negedge clk);
        assert (n_done == n_issued) else begin
            err_proc++;
            $display("Fail completion_count: expected %0d, actual %0d", n_issued, n_done);
        end
        $display("errors: %0d procedural, %0d value, %0d stability, %0d extra; %0d/%0d done",
                 err_proc, err_value, err_stable, err_extra, n_done, n_issued);
        if (err_proc + err_value + err_stable + err_extra == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
